//--- Makefile
VERILATOR  = verilator
LINT_FLAGS = --lint-only --timing
SIM_FLAGS  = --binary --timing -j 0
TOP        = tb_operand_requester
FILELIST   = operand_requester.f
OBJ_DIR    = obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "test passed"

clean:
	rm -rf $(OBJ_DIR)

//--- operand_requester.f
+incdir+test
verilog/vrf_access_pkg.sv
verilog/element_requester.sv
verilog/result_skid_register.sv
verilog/bank_arbiter.sv
verilog/operand_requester.sv
test/tb_operand_requester.sv

//--- test/tb_operand_requester_table.svh
// Columns: name, read queue mask, first vs (queue q reads vs + q), width, vl, vstart,
// ALU write enable and address, number of load writes and first address, random queue ready

localparam int NrTests = 10;

typedef struct packed {
  logic [8*16-1:0] name;
  logic [3:0]      rd_en;
  vreg_t           vs;
  vew_e            eew;
  vlen_t           vl;
  vlen_t           vstart;
  logic            alu_en;
  vaddr_t          alu_addr;
  logic [1:0]      nr_ldu;
  vaddr_t          ldu_addr;
  logic            rand_ready;
} test_t;

localparam test_t Tests [NrTests] = '{
  '{"reset_idle",      4'b0000, 5'd0, EW8,  11'd0,  11'd0, 1'b0, 10'h000, 2'd0, 10'h000, 1'b0},
  '{"read_ew64",       4'b0001, 5'd2, EW64, 11'd8,  11'd0, 1'b0, 10'h000, 2'd0, 10'h000, 1'b0},
  '{"read_ew32",       4'b0010, 5'd3, EW32, 11'd13, 11'd4, 1'b0, 10'h000, 2'd0, 10'h000, 1'b0},
  '{"read_ew8",        4'b0100, 5'd5, EW8,  11'd20, 11'd9, 1'b0, 10'h000, 2'd0, 10'h000, 1'b0},
  '{"read_ew16",       4'b1000, 5'd7, EW16, 11'd9,  11'd3, 1'b0, 10'h000, 2'd0, 10'h000, 1'b0},
  '{"alu_write",       4'b0000, 5'd0, EW8,  11'd0,  11'd0, 1'b1, 10'h0d6, 2'd0, 10'h000, 1'b0},
  '{"ldu_burst",       4'b0000, 5'd0, EW8,  11'd0,  11'd0, 1'b0, 10'h000, 2'd3, 10'h021, 1'b0},
  // Load lands in the skid one cycle before the ALU write hits the same bank
  '{"wr_contention",   4'b0000, 5'd0, EW8,  11'd0,  11'd0, 1'b1, 10'h005, 2'd1, 10'h009, 1'b0},
  '{"read_contention", 4'b0011, 5'd4, EW64, 11'd16, 11'd0, 1'b0, 10'h000, 2'd0, 10'h000, 1'b0},
  '{"random_ready",    4'b1111, 5'd8, EW32, 11'd10, 11'd0, 1'b0, 10'h000, 2'd0, 10'h000, 1'b1}
};

//--- test/tb_operand_requester.sv
`timescale 1ns/10ps

module tb_operand_requester import vrf_access_pkg::*;;

  localparam int unsigned NrBanks  = 4;
  localparam int unsigned BankBits = 2;
  localparam int          MaxSteps = 150;

  `include "tb_operand_requester_table.svh"

  logic                                   clk_i, rst_ni;
  operand_request_t [NrOperandQueues-1:0] operand_request_i;
  logic [NrOperandQueues-1:0]             operand_request_valid_i, operand_request_ready_o;
  logic [NrOperandQueues-1:0]             operand_queue_ready_i, operand_issued_o;
  logic                                   alu_result_req_i, alu_result_gnt_o;
  logic                                   ldu_result_req_i, ldu_result_gnt_o;
  result_t                                alu_result_i, ldu_result_i;
  logic [NrBanks-1:0]                     vrf_req_o;
  vrf_req_t [NrBanks-1:0]                 vrf_o;

  // Words seen on the VRF port during the current test
  vaddr_t   rd_log [NrOperandQueues][$];
  int       rd_first_cyc [NrOperandQueues];
  int       acc_cyc [NrOperandQueues];
  int       issued_cnt [NrOperandQueues];
  vrf_req_t wr_log [$];
  int       wr_bank [$];
  int       wr_cyc [$];
  int       ldu_gnt_cyc [$];
  int       alu_gnt_cyc;
  int       cyc = 0;
  int       err_cnt, fail_cnt;
  integer   seed;
  string    cur_name;

  operand_requester #(
    .NrBanks (NrBanks)
  ) DUT (.*);

  always #4 clk_i = ~clk_i;

  always @(posedge clk_i) cyc <= cyc + 1;

  ////////////////////////////////////////////////////////////
  // Expected values
  ////////////////////////////////////////////////////////////

  function automatic int words_of(test_t t);
    int epw;
    epw = 1 << (3 - int'(t.eew));
    return (int'(t.vl) + epw - 1) / epw;
  endfunction

  // Register base plus the word that holds vstart
  function automatic vaddr_t first_addr(test_t t, int q);
    int shamt;
    shamt = 3 - int'(t.eew);
    return vaddr_t'((int'(t.vs) + q) * int'(RegWords) + (int'(t.vstart) >> shamt));
  endfunction

  function automatic elen_t word_data(vaddr_t a, logic from_alu);
    logic [31:0] mix;
    mix = 32'(a) * 32'h9e3779b1;
    return {from_alu ? 16'ha1a1 : 16'h1dd1, 6'd0, a, mix};
  endfunction

  function automatic bit reads_seen(test_t t);
    for (int q = 0; q < NrOperandQueues; q++) begin
      if (t.rd_en[q] && rd_log[q].size() < words_of(t))
        return 1'b0;
    end
    return 1'b1;
  endfunction

  task automatic log_mismatch(string what, logic [127:0] expected, logic [127:0] actual);
    $display("** Error: %s %s expected %0h actual %0h", cur_name, what, expected, actual);
    err_cnt++;
  endtask

  task automatic note_failure(string msg);
    $display("%s: %s", cur_name, msg);
    err_cnt++;
  endtask

  ////////////////////////////////////////////////////////////
  // Monitor
  ////////////////////////////////////////////////////////////

  always @(negedge clk_i) begin
    logic [NrOperandQueues-1:0] seen;
    int q;
    seen = '0;
    for (int b = 0; b < NrBanks; b++) begin
      if (vrf_req_o[b] && !vrf_o[b].wen) begin
        q = int'(vrf_o[b].opqueue);
        seen[q] = 1'b1;
        if (!operand_queue_ready_i[q])
          note_failure($sformatf("queue %0d read while its operand queue was full", q));
        if (rd_log[q].size() == 0)
          rd_first_cyc[q] = cyc;
        rd_log[q].push_back(vaddr_t'(int'(vrf_o[b].addr) * NrBanks + b));
      end else if (vrf_req_o[b]) begin
        wr_log.push_back(vrf_o[b]);
        wr_bank.push_back(b);
        wr_cyc.push_back(cyc);
      end
    end
    if (seen != operand_issued_o)
      log_mismatch("issued pulses", 128'(seen), 128'(operand_issued_o));
    for (int i = 0; i < NrOperandQueues; i++)
      issued_cnt[i] += int'(operand_issued_o[i]);
    if ((operand_request_ready_o & ~operand_request_valid_i) != '0)
      note_failure("request ready raised without valid");
    if (alu_result_gnt_o && !alu_result_req_i)
      note_failure("ALU grant given without a request");
    if (ldu_result_gnt_o && !ldu_result_req_i)
      note_failure("load grant given without a request");
  end

  ////////////////////////////////////////////////////////////
  // Driver and checks
  ////////////////////////////////////////////////////////////

  task automatic check_results(test_t t);
    int          nw, idx, exp_cyc;
    vaddr_t      a;
    logic [82:0] exp_w, act_w;
    for (int q = 0; q < NrOperandQueues; q++) begin
      nw = t.rd_en[q] ? words_of(t) : 0;
      if (rd_log[q].size() != nw) begin
        log_mismatch($sformatf("queue %0d read count", q), 128'(nw), 128'(rd_log[q].size()));
      end else begin
        for (int k = 0; k < nw; k++) begin
          a = first_addr(t, q) + vaddr_t'(k);
          if (rd_log[q][k] != a)
            log_mismatch($sformatf("queue %0d word %0d address", q, k), 128'(a),
                         128'(rd_log[q][k]));
        end
        if (nw > 0 && rd_first_cyc[q] <= acc_cyc[q])
          note_failure($sformatf("queue %0d read in the cycle its request was taken", q));
      end
      if (issued_cnt[q] != nw)
        log_mismatch($sformatf("queue %0d issued count", q), 128'(nw), 128'(issued_cnt[q]));
    end
    nw = int'(t.alu_en) + int'(t.nr_ldu);
    if (wr_log.size() != nw) begin
      log_mismatch("write count", 128'(nw), 128'(wr_log.size()));
      return;
    end
    // ALU word goes first, then the loads in order
    for (int i = 0; i < nw; i++) begin
      idx = t.alu_en ? i - 1 : i;
      if (t.alu_en && i == 0) begin
        a       = t.alu_addr;
        exp_w   = {a >> BankBits, 1'b1, word_data(a, 1'b1), 8'h3c};
        exp_cyc = alu_gnt_cyc;
      end else begin
        a       = t.ldu_addr + vaddr_t'(idx);
        exp_w   = {a >> BankBits, 1'b1, word_data(a, 1'b0), strb_t'(a) | 8'h81};
        exp_cyc = t.alu_en ? -1 : ldu_gnt_cyc[idx] + 1;
      end
      act_w = {wr_log[i].addr, wr_log[i].wen, wr_log[i].wdata, wr_log[i].be};
      if (act_w != exp_w)
        log_mismatch($sformatf("write %0d word", i), 128'(exp_w), 128'(act_w));
      if (wr_bank[i] != int'(a) % NrBanks)
        log_mismatch($sformatf("write %0d bank", i), 128'(int'(a) % NrBanks), 128'(wr_bank[i]));
      if (exp_cyc >= 0 && wr_cyc[i] != exp_cyc)
        log_mismatch($sformatf("write %0d cycle", i), 128'(exp_cyc), 128'(wr_cyc[i]));
    end
  endtask

  task automatic run_test(int ti);
    test_t      t;
    logic [3:0] pend;
    int         step, ldu_sent, errs0;
    logic       alu_done;
    t        = Tests[ti];
    cur_name = $sformatf("%0s", t.name);
    errs0    = err_cnt;
    for (int q = 0; q < NrOperandQueues; q++) begin
      rd_log[q].delete();
      issued_cnt[q] = 0;
    end
    wr_log.delete();
    wr_bank.delete();
    wr_cyc.delete();
    ldu_gnt_cyc.delete();
    pend     = t.rd_en;
    ldu_sent = 0;
    alu_done = !t.alu_en;
    step     = 0;
    forever begin
      @(posedge clk_i);
      #1;
      if (step >= 4 && pend == '0 && alu_done && ldu_sent == int'(t.nr_ldu) &&
          reads_seen(t) && wr_log.size() == int'(t.alu_en) + int'(t.nr_ldu))
        break;
      if (step == MaxSteps) begin
        note_failure($sformatf("did not finish within %0d cycles", MaxSteps));
        break;
      end
      for (int q = 0; q < NrOperandQueues; q++)
        operand_request_i[q] = '{vs: t.vs + vreg_t'(q), eew: t.eew, vl: t.vl, vstart: t.vstart};
      operand_request_valid_i = pend;
      operand_queue_ready_i   = t.rand_ready ? 4'($random(seed)) : 4'hf;
      alu_result_req_i        = !alu_done && step >= 1;
      alu_result_i            = '{addr: t.alu_addr, wdata: word_data(t.alu_addr, 1'b1),
                                  be: 8'h3c};
      ldu_result_req_i        = ldu_sent < int'(t.nr_ldu);
      ldu_result_i.addr       = t.ldu_addr + vaddr_t'(ldu_sent);
      ldu_result_i.wdata      = word_data(ldu_result_i.addr, 1'b0);
      ldu_result_i.be         = strb_t'(ldu_result_i.addr) | 8'h81;
      @(negedge clk_i);
      for (int q = 0; q < NrOperandQueues; q++) begin
        if (pend[q] && operand_request_ready_o[q]) begin
          pend[q]    = 1'b0;
          acc_cyc[q] = cyc;
        end
      end
      if (alu_result_req_i && alu_result_gnt_o) begin
        alu_done    = 1'b1;
        alu_gnt_cyc = cyc;
      end
      if (ldu_result_req_i && ldu_result_gnt_o) begin
        ldu_gnt_cyc.push_back(cyc);
        ldu_sent++;
      end
      step++;
    end
    operand_request_valid_i = '0;
    alu_result_req_i        = 1'b0;
    ldu_result_req_i        = 1'b0;
    operand_queue_ready_i   = '1;
    // Let stray words show up before checking
    repeat (3) @(posedge clk_i);
    check_results(t);
    if (err_cnt == errs0) begin
      $display("%s: pass", cur_name);
    end else begin
      fail_cnt++;
      $display("%s: fail with %0d errors", cur_name, err_cnt - errs0);
    end
  endtask

  initial begin
    clk_i                   = 1'b0;
    rst_ni                  = 1'b0;
    operand_request_i       = '0;
    operand_request_valid_i = '0;
    operand_queue_ready_i   = '0;
    alu_result_req_i        = 1'b0;
    alu_result_i            = '0;
    ldu_result_req_i        = 1'b0;
    ldu_result_i            = '0;
    seed                    = 32'heec51d5c;
    err_cnt                 = 0;
    fail_cnt                = 0;
    cur_name                = "reset";
    repeat (3) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
    for (int i = 0; i < NrTests; i++)
      run_test(i);
    $display("tests %0d, failed %0d, errors %0d", NrTests, fail_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

  // Budget of 200 cycles per test
  initial begin
    #(NrTests * 200 * 8);
    $display("watchdog expired before all tests finished");
    $display("test failed");
    $finish;
  end

endmodule

//--- verilog/bank_arbiter.sv
`timescale 1ns/10ps

module bank_arbiter import vrf_access_pkg::*; #(
  parameter int unsigned NrBanks = 4,
  parameter int unsigned bank_id = 0
) (
  input  logic                                 clk_i,
  input  logic                                 rst_ni,
  // Reads from the element requesters
  input  logic     [NrOperandQueues-1:0]       read_req_i,
  input  vrf_req_t [NrOperandQueues-1:0]       read_i,
  output logic     [NrOperandQueues-1:0]       read_gnt_o,
  // Result writes
  input  logic                                 alu_req_i,
  input  result_t                              alu_i,
  output logic                                 alu_gnt_o,
  input  logic                                 ldu_req_i,
  input  result_t                              ldu_i,
  output logic                                 ldu_gnt_o,
  // VRF bank port
  output logic                                 vrf_req_o,
  output vrf_req_t                             vrf_o
);

  localparam int unsigned BankBits  = $clog2(NrBanks);
  localparam int unsigned GroupSize = 3;
  // Writer takes the last slot of each group
  localparam int unsigned WrSlot    = 2;

  ////////////////////////////////////////////////////////////
  // Write decode
  ////////////////////////////////////////////////////////////

  logic     [1:0] wr_hit;
  vrf_req_t [1:0] wr_data;

  assign wr_hit[WR_ALU]  = alu_req_i && (alu_i.addr[BankBits-1:0] == BankBits'(bank_id));
  assign wr_hit[WR_LOAD] = ldu_req_i && (ldu_i.addr[BankBits-1:0] == BankBits'(bank_id));

  // Queue tag has no meaning on a write
  assign wr_data[WR_ALU] = '{addr: alu_i.addr >> BankBits, wen: 1'b1, wdata: alu_i.wdata,
                             be: alu_i.be, opqueue: ALU_A};
  assign wr_data[WR_LOAD] = '{addr: ldu_i.addr >> BankBits, wen: 1'b1, wdata: ldu_i.wdata,
                              be: ldu_i.be, opqueue: ALU_A};

  ////////////////////////////////////////////////////////////
  // Two-group round robin
  ////////////////////////////////////////////////////////////

  logic     [GroupSize-1:0] hp_req, lp_req, hp_gnt, lp_gnt;
  vrf_req_t [GroupSize-1:0] hp_data, lp_data;
  logic     [1:0]           hp_idx, lp_idx, hp_ptr_q, lp_ptr_q;

  // First requester at or after the pointer
  function automatic logic [1:0] rr_pick(logic [GroupSize-1:0] req, logic [1:0] ptr);
    logic [1:0]  pick;
    int unsigned slot;
    pick = ptr;
    for (int i = GroupSize - 1; i >= 0; i--) begin
      slot = (int'(ptr) + i) % GroupSize;
      if (req[slot]) begin
        pick = 2'(slot);
      end
    end
    return pick;
  endfunction

  function automatic logic [1:0] rr_next(logic [1:0] idx);
    return (idx == 2'(GroupSize - 1)) ? 2'd0 : idx + 2'd1;
  endfunction

  assign hp_req  = {wr_hit[WR_ALU], read_req_i[ALU_B], read_req_i[ALU_A]};
  assign lp_req  = {wr_hit[WR_LOAD], read_req_i[STORE_D], read_req_i[MASK_M]};
  assign hp_data = {wr_data[WR_ALU], read_i[ALU_B], read_i[ALU_A]};
  assign lp_data = {wr_data[WR_LOAD], read_i[STORE_D], read_i[MASK_M]};

  assign hp_idx = rr_pick(hp_req, hp_ptr_q);
  assign lp_idx = rr_pick(lp_req, lp_ptr_q);

  always_comb begin
    hp_gnt    = '0;
    lp_gnt    = '0;
    vrf_req_o = 1'b0;
    vrf_o     = '0;
    // Any high group request masks the low group
    if (|hp_req) begin
      hp_gnt[hp_idx] = 1'b1;
      vrf_req_o      = 1'b1;
      vrf_o          = hp_data[hp_idx];
    end else if (|lp_req) begin
      lp_gnt[lp_idx] = 1'b1;
      vrf_req_o      = 1'b1;
      vrf_o          = lp_data[lp_idx];
    end
  end

  assign read_gnt_o[ALU_A]   = hp_gnt[0];
  assign read_gnt_o[ALU_B]   = hp_gnt[1];
  assign read_gnt_o[MASK_M]  = lp_gnt[0];
  assign read_gnt_o[STORE_D] = lp_gnt[1];
  assign alu_gnt_o           = hp_gnt[WrSlot];
  assign ldu_gnt_o           = lp_gnt[WrSlot];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      hp_ptr_q <= '0;
      lp_ptr_q <= '0;
    end else begin
      if (|hp_gnt) hp_ptr_q <= rr_next(hp_idx);
      if (|lp_gnt) lp_ptr_q <= rr_next(lp_idx);
    end
  end

endmodule

//--- verilog/element_requester.sv
`timescale 1ns/10ps

module element_requester import vrf_access_pkg::*; #(
  parameter int unsigned NrBanks  = 4,
  parameter opqueue_e    queue_id = ALU_A
) (
  input  logic               clk_i,
  input  logic               rst_ni,
  // Whole-register read command
  input  operand_request_t   req_i,
  input  logic               req_valid_i,
  output logic               req_ready_o,
  // Operand queue back-pressure
  input  logic               queue_ready_i,
  // Word reads towards the bank arbiters
  output logic [NrBanks-1:0] bank_req_o,
  output vrf_req_t           vrf_req_o,
  input  logic               gnt_i
);

  localparam int unsigned BankBits = $clog2(NrBanks);

  typedef enum logic {
    IDLE,
    REQUESTING
  } state_e;

  // Progress through the current operand
  typedef struct packed {
    vaddr_t addr;
    vlen_t  len;
    vew_e   vew;
  } walk_t;

  state_e state_d, state_q;
  walk_t  walk_d, walk_q;

  logic [BankBits-1:0] bank_sel;
  vlen_t               epw;
  vaddr_t              start_addr;

  assign bank_sel = walk_q.addr[BankBits-1:0];
  assign epw      = elems_per_word(walk_q.vew);

  // Register base plus the word holding the start element
  assign start_addr = vaddr_t'(req_i.vs) * vaddr_t'(RegWords) +
                      vaddr_t'(req_i.vstart >> (int'(EW64) - int'(req_i.eew)));

  always_comb begin
    state_d     = state_q;
    walk_d      = walk_q;
    req_ready_o = 1'b0;
    bank_req_o  = '0;

    if (state_q == REQUESTING && queue_ready_i) begin
      bank_req_o[bank_sel] = 1'b1;
      if (gnt_i) begin
        walk_d.addr = walk_q.addr + vaddr_t'(1);
        // Saturate on a partially filled last word
        if (walk_q.len <= epw) begin
          walk_d.len = '0;
        end else begin
          walk_d.len = walk_q.len - epw;
        end
        if (walk_d.len == '0) begin
          state_d = IDLE;
        end
      end
    end

    // Idle now, or issuing the last word this cycle
    if (state_d == IDLE && req_valid_i) begin
      req_ready_o = 1'b1;
      walk_d      = '{addr: start_addr, len: req_i.vl, vew: req_i.eew};
      state_d     = (req_i.vl == '0) ? IDLE : REQUESTING;
    end
  end

  assign vrf_req_o = '{
    addr:    walk_q.addr >> BankBits,
    wen:     1'b0,
    wdata:   '0,
    be:      '0,
    opqueue: queue_id
  };

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
      walk_q  <= '0;
    end else begin
      state_q <= state_d;
      walk_q  <= walk_d;
    end
  end

endmodule

//--- verilog/operand_requester.sv
`timescale 1ns/10ps

module operand_requester import vrf_access_pkg::*; #(
  parameter int unsigned NrBanks = 4
) (
  input  logic                                     clk_i,
  input  logic                                     rst_ni,
  // Read commands
  input  operand_request_t [NrOperandQueues-1:0]   operand_request_i,
  input  logic             [NrOperandQueues-1:0]   operand_request_valid_i,
  output logic             [NrOperandQueues-1:0]   operand_request_ready_o,
  // Operand queues
  input  logic             [NrOperandQueues-1:0]   operand_queue_ready_i,
  output logic             [NrOperandQueues-1:0]   operand_issued_o,
  // Result writers
  input  logic                                     alu_result_req_i,
  input  result_t                                  alu_result_i,
  output logic                                     alu_result_gnt_o,
  input  logic                                     ldu_result_req_i,
  input  result_t                                  ldu_result_i,
  output logic                                     ldu_result_gnt_o,
  // VRF
  output logic             [NrBanks-1:0]           vrf_req_o,
  output vrf_req_t         [NrBanks-1:0]           vrf_o
);

  logic     [NrOperandQueues-1:0][NrBanks-1:0] queue_bank_req, queue_bank_gnt;
  logic     [NrBanks-1:0][NrOperandQueues-1:0] bank_read_req, bank_read_gnt;
  vrf_req_t [NrOperandQueues-1:0]              queue_req;
  logic     [NrBanks-1:0]                      bank_alu_gnt, bank_ldu_gnt;

  logic    ldu_skid_free, ldu_skid_req, ldu_skid_gnt;
  result_t ldu_skid_data;

  ////////////////////////////////////////////////////////////
  // Element requesters
  ////////////////////////////////////////////////////////////

  for (genvar q = 0; q < NrOperandQueues; q++) begin : gen_requester
    // Word issued when any bank granted it
    assign operand_issued_o[q] = |queue_bank_gnt[q];

    element_requester #(
      .NrBanks  (NrBanks),
      .queue_id (opqueue_e'(q))
    ) i_element_requester (
      .clk_i         (clk_i),
      .rst_ni        (rst_ni),
      .req_i         (operand_request_i[q]),
      .req_valid_i   (operand_request_valid_i[q]),
      .req_ready_o   (operand_request_ready_o[q]),
      .queue_ready_i (operand_queue_ready_i[q]),
      .bank_req_o    (queue_bank_req[q]),
      .vrf_req_o     (queue_req[q]),
      .gnt_i         (operand_issued_o[q])
    );

    for (genvar b = 0; b < NrBanks; b++) begin : gen_transpose
      assign bank_read_req[b][q]  = queue_bank_req[q][b];
      assign queue_bank_gnt[q][b] = bank_read_gnt[b][q];
    end
  end

  // Load results wait one cycle in the skid slot
  assign ldu_result_gnt_o = ldu_result_req_i && ldu_skid_free;
  assign ldu_skid_gnt     = |bank_ldu_gnt;
  assign alu_result_gnt_o = |bank_alu_gnt;

  result_skid_register i_ldu_skid (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .req_i  (ldu_result_req_i),
    .data_i (ldu_result_i),
    .free_o (ldu_skid_free),
    .req_o  (ldu_skid_req),
    .data_o (ldu_skid_data),
    .gnt_i  (ldu_skid_gnt)
  );

  ////////////////////////////////////////////////////////////
  // Per-bank arbitration
  ////////////////////////////////////////////////////////////

  for (genvar b = 0; b < NrBanks; b++) begin : gen_bank
    bank_arbiter #(
      .NrBanks (NrBanks),
      .bank_id (b)
    ) i_bank_arbiter (
      .clk_i      (clk_i),
      .rst_ni     (rst_ni),
      .read_req_i (bank_read_req[b]),
      .read_i     (queue_req),
      .read_gnt_o (bank_read_gnt[b]),
      .alu_req_i  (alu_result_req_i),
      .alu_i      (alu_result_i),
      .alu_gnt_o  (bank_alu_gnt[b]),
      .ldu_req_i  (ldu_skid_req),
      .ldu_i      (ldu_skid_data),
      .ldu_gnt_o  (bank_ldu_gnt[b]),
      .vrf_req_o  (vrf_req_o[b]),
      .vrf_o      (vrf_o[b])
    );
  end

endmodule

//--- verilog/result_skid_register.sv
`timescale 1ns/10ps

module result_skid_register import vrf_access_pkg::*; (
  input  logic    clk_i,
  input  logic    rst_ni,
  // From the load unit
  input  logic    req_i,
  input  result_t data_i,
  output logic    free_o,
  // Towards the bank arbiters
  output logic    req_o,
  output result_t data_o,
  input  logic    gnt_i
);

  logic    valid_q;
  result_t data_q;
  logic    load;

  // Slot opens up in the same cycle the held word is granted
  assign free_o = !valid_q || gnt_i;
  assign load   = req_i && free_o;

  assign req_o  = valid_q;
  assign data_o = data_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
    end else if (load) begin
      valid_q <= 1'b1;
    end else if (gnt_i) begin
      valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (load) begin
      data_q <= data_i;
    end
  end

endmodule

//--- verilog/vrf_access_pkg.sv
package vrf_access_pkg;

  ////////////////////////////////////////////////////////////
  // Word, strobe and address types
  ////////////////////////////////////////////////////////////

  localparam int unsigned ElenWidth  = 64;
  localparam int unsigned VaddrWidth = 10;

  typedef logic [ElenWidth-1:0]   elen_t;
  typedef logic [ElenWidth/8-1:0] strb_t;

  // Lane-local word address, low bits pick the bank
  typedef logic [VaddrWidth-1:0] vaddr_t;

  typedef logic [4:0]  vreg_t;
  typedef logic [10:0] vlen_t;

  // Words per vector register in this lane
  localparam int unsigned RegWords = 8;

  ////////////////////////////////////////////////////////////
  // Encodings
  ////////////////////////////////////////////////////////////

  typedef enum logic [1:0] {
    EW8  = 2'd0,
    EW16 = 2'd1,
    EW32 = 2'd2,
    EW64 = 2'd3
  } vew_e;

  // ALU_A and ALU_B form the high priority group
  typedef enum logic [1:0] {
    ALU_A   = 2'd0,
    ALU_B   = 2'd1,
    MASK_M  = 2'd2,
    STORE_D = 2'd3
  } opqueue_e;

  localparam int unsigned NrOperandQueues = 4;

  // ALU writes are high priority, load writes low
  typedef enum logic {
    WR_ALU  = 1'b0,
    WR_LOAD = 1'b1
  } writer_e;

  ////////////////////////////////////////////////////////////
  // Bundles
  ////////////////////////////////////////////////////////////

  typedef struct packed {
    vreg_t vs;
    vew_e  eew;
    vlen_t vl;
    vlen_t vstart;
  } operand_request_t;

  typedef struct packed {
    vaddr_t addr;
    elen_t  wdata;
    strb_t  be;
  } result_t;

  // Address here is the in-bank address
  typedef struct packed {
    vaddr_t   addr;
    logic     wen;
    elen_t    wdata;
    strb_t    be;
    opqueue_e opqueue;
  } vrf_req_t;

  // Elements of a given width packed in one VRF word
  function automatic vlen_t elems_per_word(vew_e ew);
    return vlen_t'(1) << (int'(EW64) - int'(ew));
  endfunction

endpackage
